// ==== uart_params.svh ====
// Size and width macros for the UART peripheral, included by the package and every RTL module
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Number of UART channels on the bus
`define UART_CH 3

// Channel index width, index 3 is left unmapped
`define UART_CH_W 2

// Bus and serial data width
`define UART_DAT 8

// Baud divisor width
`define UART_DIV_W 8

// FIFO depth and derived pointer and counter widths
`define FIFO_DEPTH 4
`define FIFO_ADR_W 2
`define FIFO_CNT_W 3

// Bus address width, channel in the upper bits, register in the lower two
`define BUS_ADR_W 4

`endif

// ==== uart_pkg.sv ====
// Shared types for the UART peripheral; compile first and import where the types are needed
package uart_pkg;

`include "uart_params.svh"

    // Widths with a meaning
    typedef logic [`UART_DAT-1:0]   uart_data_t;
    typedef logic [`UART_DIV_W-1:0] uart_div_t;
    typedef logic [`FIFO_CNT_W-1:0] fifo_cnt_t;
    typedef logic [`UART_CH_W-1:0]  ch_idx_t;
    typedef logic [`BUS_ADR_W-1:0]  bus_adr_t;

    // Channel register map, low two address bits
    typedef enum logic [1:0] {
        REG_DATA   = 2'd0,
        REG_STATUS = 2'd1,
        REG_DIV    = 2'd2,
        REG_IRQ    = 2'd3
    } reg_sel_e;

    // Transmitter shifter states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    // Receiver shifter states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    // Bus request, plain strobes
    typedef struct packed {
        logic       wen;
        logic       ren;
        bus_adr_t   adr;
        uart_data_t wdt;
    } bus_req_t;

    // Per channel request after decode
    typedef struct packed {
        logic       wen;
        logic       ren;
        reg_sel_e   sel;
        uart_data_t wdt;
    } ch_req_t;

    // Read select handed to the collector
    typedef struct packed {
        logic    hit;
        ch_idx_t ch;
    } rd_sel_t;

    // Per channel response
    typedef struct packed {
        uart_data_t rdt;
        logic       irq_tx;
        logic       irq_rx;
    } ch_rsp_t;

endpackage: uart_pkg

// ==== uart_fifo.sv ====
// Small synchronous FIFO with occupancy count; one instance each for TX and RX in a UART channel
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_fifo (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  logic                  pop,
    input  uart_pkg::uart_data_t  wdt,
    output uart_pkg::uart_data_t  rdt,
    output uart_pkg::fifo_cnt_t   cnt,
    output logic                  full,
    output logic                  empty
);

    import uart_pkg::*;

    // Storage, no reset
    uart_data_t              mem [`FIFO_DEPTH];

    // Circular pointers, wrap on their own since depth is a power of two
    logic [`FIFO_ADR_W-1:0]  wptr;
    logic [`FIFO_ADR_W-1:0]  rptr;

    // Qualified requests
    logic                    do_push;
    logic                    do_pop;

    assign full    = (cnt == fifo_cnt_t'(`FIFO_DEPTH));
    assign empty   = (cnt == '0);
    // Push into a full FIFO is dropped
    assign do_push = push && !full;
    // Pop from an empty FIFO does nothing
    assign do_pop  = pop && !empty;

    // Pointers and count
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wptr <= '0;
            rptr <= '0;
            cnt  <= '0;
        end
        else
        begin
            if (do_push)
                wptr <= wptr + 1'b1;
            if (do_pop)
                rptr <= rptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    // Write port
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wptr] <= wdt;
    end

    // Head of queue, read combinationally
    assign rdt = mem[rptr];

    // Occupancy bounded by depth
    assert property (@(posedge clk) disable iff (reset) cnt <= fifo_cnt_t'(`FIFO_DEPTH))
    else $error("FIFO count above depth");

endmodule: uart_fifo

// ==== uart_req_decode.sv ====
// Bus request decoder; steers the strobes of one bus access to the addressed UART channel
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_req_decode (
    input  uart_pkg::bus_req_t req,
    output uart_pkg::ch_req_t  ch_req [`UART_CH],
    output uart_pkg::rd_sel_t  rd_sel
);

    import uart_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Address split
    ////////////////////////////////////////////////////////////////////////////

    ch_idx_t                 idx;
    reg_sel_e                sel;
    logic                    mapped;
    logic [`UART_CH-1:0]     stb;

    // Channel index in the upper address bits
    assign idx = req.adr[`BUS_ADR_W-1 -: `UART_CH_W];

    // Register select in the lower bits
    assign sel = reg_sel_e'(req.adr[`BUS_ADR_W-`UART_CH_W-1:0]);

    // Index 3 is a hole in the map
    assign mapped = (idx < ch_idx_t'(`UART_CH));

    ////////////////////////////////////////////////////////////////////////////
    // Strobe steering
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < `UART_CH; i++)
        begin
            // Only the addressed channel sees a strobe
            ch_req[i].wen = req.wen && mapped && (idx == ch_idx_t'(i));
            ch_req[i].ren = req.ren && mapped && (idx == ch_idx_t'(i));
            // Payload fans out to all channels
            ch_req[i].sel = sel;
            ch_req[i].wdt = req.wdt;
        end
    end

    // Collector needs the read target one cycle later
    assign rd_sel.hit = req.ren && mapped;
    assign rd_sel.ch  = idx;

    // Never more than one channel strobed, reads and writes together
    always_comb
    begin
        for (int i = 0; i < `UART_CH; i++)
        begin
            stb[i] = ch_req[i].wen | ch_req[i].ren;
        end
        assert ($onehot0(stb))
        else $error("decoder strobes more than one channel");
    end

endmodule: uart_req_decode

// ==== uart_channel.sv ====
// One 8N1 UART channel with data, status, divisor and interrupt-level registers and two FIFOs
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_channel (
    input  logic               clk,
    input  logic               reset,
    input  uart_pkg::ch_req_t  req,
    output uart_pkg::ch_rsp_t  rsp,
    input  logic               rxd,
    output logic               txd
);

    import uart_pkg::*;

    localparam int unsigned BIT_W = $clog2(`UART_DAT);

    ////////////////////////////////////////////////////////////////////////////
    // Registers and FIFOs
    ////////////////////////////////////////////////////////////////////////////

    // Configuration
    uart_div_t   div;
    fifo_cnt_t   lvl_tx;
    fifo_cnt_t   lvl_rx;
    uart_data_t  rdt_q;

    // FIFO hookup
    logic        tx_push;
    logic        tx_pop;
    logic        tx_empty;
    logic        rx_push;
    logic        rx_pop;
    logic        rx_empty;
    uart_data_t  tx_rdt;
    uart_data_t  rx_rdt;
    uart_data_t  rx_shr;
    fifo_cnt_t   tx_cnt;
    fifo_cnt_t   rx_cnt;

    // Transmitter
    tx_state_e         tx_state;
    uart_div_t         tx_bcnt;
    logic [BIT_W-1:0]  tx_bit;
    uart_data_t        tx_shr;
    logic              txd_q;

    // Receiver
    rx_state_e         rx_state;
    uart_div_t         rx_bcnt;
    logic [BIT_W-1:0]  rx_bit;
    logic              rxd_s1;
    logic              rxd_s2;
    logic              rxd_prev;

    // Data register accesses
    assign tx_push = req.wen && (req.sel == REG_DATA);
    assign rx_pop  = req.ren && (req.sel == REG_DATA);

    // Divisor and levels
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div    <= '0;
            lvl_tx <= '0;
            lvl_rx <= '0;
        end
        else if (req.wen)
        begin
            if (req.sel == REG_DIV)
                div <= uart_div_t'(req.wdt);
            if (req.sel == REG_IRQ)
            begin
                lvl_tx <= req.wdt[`FIFO_CNT_W-1:0];
                lvl_rx <= req.wdt[4 +: `FIFO_CNT_W];
            end
        end
    end

    // Read data held until the next read
    always_ff @(posedge clk)
    begin
        if (req.ren)
        begin
            case (req.sel)
                // Empty RX FIFO reads as zero
                REG_DATA:   rdt_q <= rx_empty ? '0 : rx_rdt;
                // Busy, TX count, RX count
                REG_STATUS: rdt_q <= {tx_state != TX_IDLE, tx_cnt, 1'b0, rx_cnt};
                REG_DIV:    rdt_q <= uart_data_t'(div);
                REG_IRQ:    rdt_q <= {1'b0, lvl_rx, 1'b0, lvl_tx};
                default:    rdt_q <= '0;
            endcase
        end
    end

    // Response and level interrupts
    assign rsp.rdt    = rdt_q;
    assign rsp.irq_tx = (tx_cnt < lvl_tx);
    assign rsp.irq_rx = (rx_cnt > lvl_rx);

    uart_fifo tx_fifo_i (
        .clk   (clk),
        .reset (reset),
        .push  (tx_push),
        .pop   (tx_pop),
        .wdt   (req.wdt),
        .rdt   (tx_rdt),
        .cnt   (tx_cnt),
        .full  (),
        .empty (tx_empty)
    );

    uart_fifo rx_fifo_i (
        .clk   (clk),
        .reset (reset),
        .push  (rx_push),
        .pop   (rx_pop),
        .wdt   (rx_shr),
        .rdt   (rx_rdt),
        .cnt   (rx_cnt),
        .full  (),
        .empty (rx_empty)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Transmitter
    ////////////////////////////////////////////////////////////////////////////

    // Idle shifter takes the next byte
    assign tx_pop = (tx_state == TX_IDLE) && !tx_empty;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tx_state <= TX_IDLE;
            tx_bcnt  <= '0;
            tx_bit   <= '0;
            txd_q    <= 1'b1;
        end
        else
        begin
            // Bit time is div+1 cycles
            tx_bcnt <= (tx_bcnt == div) ? '0 : tx_bcnt + 1'b1;
            case (tx_state)
                TX_IDLE:
                begin
                    tx_bcnt <= '0;
                    if (!tx_empty)
                    begin
                        tx_state <= TX_START;
                        txd_q    <= 1'b0;
                    end
                end
                TX_START:
                    if (tx_bcnt == div)
                    begin
                        tx_state <= TX_DATA;
                        tx_bit   <= '0;
                        txd_q    <= tx_shr[0];
                    end
                TX_DATA:
                    if (tx_bcnt == div)
                    begin
                        tx_bit <= tx_bit + 1'b1;
                        // LSB first with the next bit at index 1 before the shift
                        txd_q  <= tx_shr[1];
                        if (tx_bit == BIT_W'(`UART_DAT-1))
                        begin
                            tx_state <= TX_STOP;
                            txd_q    <= 1'b1;
                        end
                    end
                default:
                    if (tx_bcnt == div)
                        tx_state <= TX_IDLE;
            endcase
        end
    end

    // Shift register payload
    always_ff @(posedge clk)
    begin
        if (tx_pop)
            tx_shr <= tx_rdt;
        else if ((tx_state == TX_DATA) && (tx_bcnt == div))
            tx_shr <= tx_shr >> 1;
    end

    assign txd = txd_q;

    // Line rests high between frames
    assert property (@(posedge clk) disable iff (reset) (tx_state == TX_IDLE) |-> txd)
    else $error("txd low while transmitter idle");

    ////////////////////////////////////////////////////////////////////////////
    // Receiver
    ////////////////////////////////////////////////////////////////////////////

    // Two flop synchronizer plus edge history
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rxd_s1   <= 1'b1;
            rxd_s2   <= 1'b1;
            rxd_prev <= 1'b1;
        end
        else
        begin
            rxd_s1   <= rxd;
            rxd_s2   <= rxd_s1;
            rxd_prev <= rxd_s2;
        end
    end

    // Push at mid stop bit only when the line is high
    assign rx_push = (rx_state == RX_STOP) && (rx_bcnt == div) && rxd_s2;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_state <= RX_IDLE;
            rx_bcnt  <= '0;
            rx_bit   <= '0;
        end
        else
        begin
            rx_bcnt <= rx_bcnt + 1'b1;
            case (rx_state)
                RX_IDLE:
                begin
                    rx_bcnt <= '0;
                    // Falling edge opens a frame
                    if (rxd_prev && !rxd_s2)
                        rx_state <= RX_START;
                end
                RX_START:
                    // A high line at mid start bit was a glitch
                    if (rx_bcnt == (div >> 1))
                    begin
                        rx_bcnt  <= '0;
                        rx_bit   <= '0;
                        rx_state <= rxd_s2 ? RX_IDLE : RX_DATA;
                    end
                RX_DATA:
                    if (rx_bcnt == div)
                    begin
                        rx_bcnt <= '0;
                        rx_bit  <= rx_bit + 1'b1;
                        if (rx_bit == BIT_W'(`UART_DAT-1))
                            rx_state <= RX_STOP;
                    end
                default:
                    if (rx_bcnt == div)
                        rx_state <= RX_IDLE;
            endcase
        end
    end

    // Sampled bits enter from the top
    always_ff @(posedge clk)
    begin
        if ((rx_state == RX_DATA) && (rx_bcnt == div))
            rx_shr <= {rxd_s2, rx_shr[`UART_DAT-1:1]};
    end

endmodule: uart_channel

// ==== uart_rsp_collect.sv ====
// Response collector; returns the addressed channel's read data and gathers interrupt vectors
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rsp_collect (
    input  logic                  clk,
    input  logic                  reset,
    input  uart_pkg::rd_sel_t     rd_sel,
    input  uart_pkg::ch_rsp_t     ch_rsp [`UART_CH],
    output uart_pkg::uart_data_t  rdt,
    output logic [`UART_CH-1:0]   irq_tx,
    output logic [`UART_CH-1:0]   irq_rx
);

    import uart_pkg::*;

    // Read select aligned with the channel read data
    rd_sel_t  sel_q;

    always_ff @(posedge clk)
    begin
        if (reset)
            sel_q <= '0;
        else
            sel_q <= rd_sel;
    end

    // Read data mux, zero without a hit
    always_comb
    begin
        rdt = '0;
        if (sel_q.hit)
        begin
            for (int i = 0; i < `UART_CH; i++)
            begin
                if (sel_q.ch == ch_idx_t'(i))
                    rdt = ch_rsp[i].rdt;
            end
        end
    end

    // Interrupt vectors
    always_comb
    begin
        for (int i = 0; i < `UART_CH; i++)
        begin
            irq_tx[i] = ch_rsp[i].irq_tx;
            irq_rx[i] = ch_rsp[i].irq_rx;
        end
    end

    // Decoder never lets a hit through for the hole
    assert property (@(posedge clk) disable iff (reset)
        sel_q.hit |-> (sel_q.ch < ch_idx_t'(`UART_CH)))
    else $error("read hit on unmapped channel");

endmodule: uart_rsp_collect

// ==== uart_peri_top.sv ====
// Top level of the multi-channel UART peripheral; connect the register bus and the serial lines
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_peri_top (
    input  logic                  clk,
    input  logic                  reset,
    // Register bus
    input  uart_pkg::bus_req_t    req,
    output uart_pkg::uart_data_t  rdt,
    // Serial lines
    input  logic [`UART_CH-1:0]   rxd,
    output logic [`UART_CH-1:0]   txd,
    // Interrupts
    output logic [`UART_CH-1:0]   irq_tx,
    output logic [`UART_CH-1:0]   irq_rx
);

    import uart_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Request fan out and response fan in
    ////////////////////////////////////////////////////////////////////////////

    ch_req_t  ch_req [`UART_CH];
    ch_rsp_t  ch_rsp [`UART_CH];
    rd_sel_t  rd_sel;

    uart_req_decode decode_i (
        .req    (req),
        .ch_req (ch_req),
        .rd_sel (rd_sel)
    );

    // Identical channels
    for (genvar i = 0; i < `UART_CH; i++)
    begin: ch_g
        uart_channel channel_i (
            .clk   (clk),
            .reset (reset),
            .req   (ch_req[i]),
            .rsp   (ch_rsp[i]),
            .rxd   (rxd[i]),
            .txd   (txd[i])
        );
    end

    uart_rsp_collect collect_i (
        .clk    (clk),
        .reset  (reset),
        .rd_sel (rd_sel),
        .ch_rsp (ch_rsp),
        .rdt    (rdt),
        .irq_tx (irq_tx),
        .irq_rx (irq_rx)
    );

endmodule: uart_peri_top

// ==== tb_uart_peri.sv ====
// Table-driven testbench for the UART peripheral, with the three channels in a serial loopback ring
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_uart_peri;

    import uart_pkg::*;

    localparam int PERIOD  = 100;
    localparam int DRV_DLY = 10;
    localparam int MARGIN  = 1000;

    // Row operations
    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_POLL,
        OP_IRQ,
        OP_TXD
    } op_e;

    // One table row, the name travels in a queue of its own
    typedef struct packed {
        op_e        op;
        ch_idx_t    ch;
        reg_sel_e   sel;
        uart_data_t dat;
        uart_data_t exp;
    } row_t;

    logic                 clk;
    logic                 reset;
    bus_req_t             req;
    uart_data_t           rdt;
    logic [`UART_CH-1:0]  rxd;
    logic [`UART_CH-1:0]  txd;
    logic [`UART_CH-1:0]  irq_tx;
    logic [`UART_CH-1:0]  irq_rx;

    row_t        rows [$];
    string       names [$];
    uart_data_t  pay [11];
    integer      seed;
    int          n_rows;

    uart_peri_top dut_i (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .rdt    (rdt),
        .rxd    (rxd),
        .txd    (txd),
        .irq_tx (irq_tx),
        .irq_rx (irq_rx)
    );

    // Ring, txd[i] feeds rxd[i+1]
    assign rxd = {txd[1:0], txd[2]};

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD/2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus access and checks
    ////////////////////////////////////////////////////////////////////////////

    // One strobe cycle, then idle; read data sampled in the cycle after ren
    task automatic bus_access(input logic wen, input logic ren, input ch_idx_t ch,
                              input reg_sel_e sel, input uart_data_t wdt,
                              output uart_data_t data);
        @(posedge clk);
        #(DRV_DLY);
        req.wen = wen;
        req.ren = ren;
        req.adr = bus_adr_t'({ch, sel});
        req.wdt = wdt;
        @(posedge clk);
        #(DRV_DLY);
        req  = '0;
        data = rdt;
    endtask

    task automatic report_mismatch(input string name, input uart_data_t exp,
                                   input uart_data_t act);
        $display("MISMATCH %s expected 0x%02h actual 0x%02h", name, exp, act);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input uart_data_t exp,
                               input uart_data_t act);
        assert (act === exp)
        else report_mismatch(name, exp, act);
    endtask

    // Status poll until equal, RX count must never pass the target
    task automatic poll_status(input string name, input ch_idx_t ch, input uart_data_t exp);
        uart_data_t sts;
        do
        begin
            bus_access(1'b0, 1'b1, ch, REG_STATUS, '0, sts);
            assert (sts[2:0] <= exp[2:0])
            else report_mismatch(name, exp, sts);
        end
        while (sts !== exp);
    endtask

    task automatic apply_row(input string name, input row_t r);
        uart_data_t act;
        case (r.op)
            OP_WR:
                bus_access(1'b1, 1'b0, r.ch, r.sel, r.dat, act);
            OP_RD:
            begin
                bus_access(1'b0, 1'b1, r.ch, r.sel, '0, act);
                check_value(name, r.exp, act);
            end
            OP_POLL:
                poll_status(name, r.ch, r.exp);
            // Pins as {irq_rx, irq_tx}
            OP_IRQ:
            begin
                @(posedge clk);
                #(DRV_DLY);
                check_value(name, r.exp, uart_data_t'({irq_rx, irq_tx}));
            end
            default:
            begin
                @(posedge clk);
                #(DRV_DLY);
                check_value(name, r.exp, uart_data_t'(txd));
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test table
    ////////////////////////////////////////////////////////////////////////////

    function automatic void add_row(input string name, input op_e op, input ch_idx_t ch,
                                    input reg_sel_e sel, input uart_data_t dat,
                                    input uart_data_t exp);
        row_t r;
        r.op  = op;
        r.ch  = ch;
        r.sel = sel;
        r.dat = dat;
        r.exp = exp;
        rows.push_back(r);
        names.push_back(name);
    endfunction

    function automatic void build_table();
        string tag;
        for (int k = 0; k < 11; k++)
            pay[k] = uart_data_t'($random(seed));
        // Reset values
        for (int c = 0; c < `UART_CH; c++)
        begin
            tag = $sformatf(" ch%0d", c);
            add_row({"reset status", tag}, OP_RD, ch_idx_t'(c), REG_STATUS, 8'h00, 8'h00);
            add_row({"reset div", tag}, OP_RD, ch_idx_t'(c), REG_DIV, 8'h00, 8'h00);
            add_row({"reset levels", tag}, OP_RD, ch_idx_t'(c), REG_IRQ, 8'h00, 8'h00);
        end
        add_row("reset empty data", OP_RD, 2'd0, REG_DATA, 8'h00, 8'h00);
        add_row("reset irq pins", OP_IRQ, 2'd0, REG_DATA, 8'h00, 8'h00);
        add_row("reset txd lines", OP_TXD, 2'd0, REG_DATA, 8'h00, 8'h07);
        add_row("hole status", OP_RD, 2'd3, REG_STATUS, 8'h00, 8'h00);
        // Register isolation, unused level bits read as zero
        add_row("div ch0 write", OP_WR, 2'd0, REG_DIV, 8'h5a, 8'h00);
        add_row("div ch0", OP_RD, 2'd0, REG_DIV, 8'h00, 8'h5a);
        add_row("div ch1 untouched", OP_RD, 2'd1, REG_DIV, 8'h00, 8'h00);
        add_row("div ch2 untouched", OP_RD, 2'd2, REG_DIV, 8'h00, 8'h00);
        add_row("levels ch1 write", OP_WR, 2'd1, REG_IRQ, 8'hff, 8'h00);
        add_row("levels ch1", OP_RD, 2'd1, REG_IRQ, 8'h00, 8'h77);
        add_row("levels ch0 untouched", OP_RD, 2'd0, REG_IRQ, 8'h00, 8'h00);
        add_row("levels ch2 untouched", OP_RD, 2'd2, REG_IRQ, 8'h00, 8'h00);
        add_row("irq tx ch1 level 7", OP_IRQ, 2'd0, REG_DATA, 8'h00, 8'h02);
        add_row("levels ch1 clear", OP_WR, 2'd1, REG_IRQ, 8'h00, 8'h00);
        add_row("irq pins clear", OP_IRQ, 2'd0, REG_DATA, 8'h00, 8'h00);
        add_row("hole div write", OP_WR, 2'd3, REG_DIV, 8'hff, 8'h00);
        add_row("hole div", OP_RD, 2'd3, REG_DIV, 8'h00, 8'h00);
        add_row("div ch0 after hole", OP_RD, 2'd0, REG_DIV, 8'h00, 8'h5a);
        add_row("div ch1 after hole", OP_RD, 2'd1, REG_DIV, 8'h00, 8'h00);
        add_row("div ch2 after hole", OP_RD, 2'd2, REG_DIV, 8'h00, 8'h00);
        // Loopback ch0 to ch1
        add_row("loop div ch0", OP_WR, 2'd0, REG_DIV, 8'h07, 8'h00);
        add_row("loop div ch1", OP_WR, 2'd1, REG_DIV, 8'h07, 8'h00);
        for (int k = 0; k < 4; k++)
            add_row($sformatf("loop send %0d", k), OP_WR, 2'd0, REG_DATA, pay[k], 8'h00);
        add_row("loop rx count", OP_POLL, 2'd1, REG_STATUS, 8'h00, 8'h04);
        for (int k = 0; k < 4; k++)
            add_row($sformatf("loop recv %0d", k), OP_RD, 2'd1, REG_DATA, 8'h00, pay[k]);
        add_row("loop drained", OP_RD, 2'd1, REG_DATA, 8'h00, 8'h00);
        // Level interrupts
        add_row("irq tx level ch2", OP_WR, 2'd2, REG_IRQ, 8'h02, 8'h00);
        add_row("irq tx ch2 high", OP_IRQ, 2'd0, REG_DATA, 8'h00, 8'h04);
        add_row("irq rx send", OP_WR, 2'd0, REG_DATA, pay[4], 8'h00);
        add_row("irq rx count", OP_POLL, 2'd1, REG_STATUS, 8'h00, 8'h01);
        add_row("irq rx ch1 high", OP_IRQ, 2'd0, REG_DATA, 8'h00, 8'h14);
        add_row("irq rx byte", OP_RD, 2'd1, REG_DATA, 8'h00, pay[4]);
        add_row("irq rx ch1 low", OP_IRQ, 2'd0, REG_DATA, 8'h00, 8'h04);
        add_row("irq levels clear", OP_WR, 2'd2, REG_IRQ, 8'h00, 8'h00);
        add_row("irq all low", OP_IRQ, 2'd0, REG_DATA, 8'h00, 8'h00);
        // Overflow ch1 to ch2, slow line keeps the shifter busy
        add_row("ovf div ch1", OP_WR, 2'd1, REG_DIV, 8'hc8, 8'h00);
        add_row("ovf div ch2", OP_WR, 2'd2, REG_DIV, 8'hc8, 8'h00);
        for (int k = 0; k < 5; k++)
            add_row($sformatf("ovf send %0d", k), OP_WR, 2'd1, REG_DATA, pay[5+k], 8'h00);
        add_row("ovf status after five", OP_RD, 2'd1, REG_STATUS, 8'h00, 8'hc0);
        add_row("ovf send dropped", OP_WR, 2'd1, REG_DATA, pay[10], 8'h00);
        add_row("ovf status after six", OP_RD, 2'd1, REG_STATUS, 8'h00, 8'hc0);
        add_row("ovf rx full", OP_POLL, 2'd2, REG_STATUS, 8'h00, 8'h04);
        add_row("ovf recv 0", OP_RD, 2'd2, REG_DATA, 8'h00, pay[5]);
        add_row("ovf rx fifth", OP_POLL, 2'd2, REG_STATUS, 8'h00, 8'h04);
        for (int k = 1; k < 5; k++)
            add_row($sformatf("ovf recv %0d", k), OP_RD, 2'd2, REG_DATA, 8'h00, pay[5+k]);
        add_row("ovf tx drained", OP_POLL, 2'd1, REG_STATUS, 8'h00, 8'h00);
        add_row("ovf no sixth byte", OP_RD, 2'd2, REG_STATUS, 8'h00, 8'h00);
        add_row("ovf empty read", OP_RD, 2'd2, REG_DATA, 8'h00, 8'h00);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Run and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        req    = '0;
        reset  = 1'b1;
        seed   = 32'h31e5;
        n_rows = 0;
        build_table();
        n_rows = rows.size();
        // Two edges in reset
        repeat (2) @(posedge clk);
        #(DRV_DLY);
        reset = 1'b0;
        for (int i = 0; i < n_rows; i++)
            apply_row(names[i], rows[i]);
        $display("ALL TESTS PASSED");
        $finish;
    end

    // Budget of one slowest frame per row
    initial
    begin
        wait (n_rows > 0);
        #(n_rows * 10 * 256 * PERIOD + MARGIN * PERIOD);
        $display("Watchdog expired before the table finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule: tb_uart_peri

// ==== sources.f ====
+incdir+.
uart_pkg.sv
uart_fifo.sv
uart_req_decode.sv
uart_channel.sv
uart_rsp_collect.sv
uart_peri_top.sv
tb_uart_peri.sv

// ==== Makefile ====
TOP = tb_uart_peri

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
